// File: Bender.yml
package:
  name: l1_cluster

sources:
  # RTL in compile order
  - files:
      - hw/cluster_pkg.sv
      - hw/rr_arbiter.sv
      - hw/tcdm_bank.sv
      - hw/tcdm_xbar.sv
      - hw/cluster_tile.sv
      - hw/l1_cluster.sv

  # Verification sources
  - target: test
    files:
      - verif/l1_cluster_chk.sv
      - verif/tb_l1_cluster.sv

// File: hw/cluster_pkg.sv
////////////////////
// Shared types and constants for the L1 cluster
// Imported by every RTL module and the testbench
////////////////////

package cluster_pkg;

  // Word and address geometry
  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // Initiator index budget, up to 1024 core ports
  localparam int unsigned MaxIniWidth = 10;

  // Row field width carried to the banks, upper bits unused
  localparam int unsigned MaxRowWidth = 16;

  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [BeWidth-1:0]     strb_t;
  typedef logic [MaxIniWidth-1:0] ini_t;

  // Request as issued by a core
  typedef struct packed {
    addr_t addr;
    logic  wen;    // 1 = write
    data_t wdata;
    strb_t be;
  } tcdm_req_t;

  // Request as seen by a bank
  typedef struct packed {
    logic [MaxRowWidth-1:0] row;
    ini_t                   ini;
    logic                   wen;
    data_t                  wdata;
    strb_t                  be;
  } bank_req_t;

  // Read response, ini selects the return port
  typedef struct packed {
    data_t rdata;
    ini_t  ini;
  } bank_resp_t;

  // Returned for reads outside the TCDM window
  localparam data_t ErrData = 32'hbadc_0ffe;

endpackage : cluster_pkg

// File: hw/cluster_tile.sv
////////////////////
// Tile with its core ports' address decode and its share of banks
////////////////////

`timescale 1ns/1ps

module cluster_tile #(
  parameter int unsigned         NumCoresPerTile = 2,
  parameter int unsigned         NumBanksPerTile = 4,
  parameter int unsigned         NumBanks        = 8,
  parameter cluster_pkg::addr_t  TCDMBaseAddr    = 32'h0001_0000,
  parameter int unsigned         TCDMSizePerBank = 256,
  parameter int unsigned         RowWidth        = 6,
  // Derived, leave at default
  parameter int unsigned         BankSelWidth    = (NumBanks > 1) ? $clog2(NumBanks) : 1
) (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  logic [cluster_pkg::MaxIniWidth-1:0]            tile_id_i,
  // Core side
  input  logic [NumCoresPerTile-1:0]                     core_req_i,
  input  cluster_pkg::tcdm_req_t [NumCoresPerTile-1:0]   core_qry_i,
  output logic [NumCoresPerTile-1:0]                     core_gnt_o,
  output logic [NumCoresPerTile-1:0]                     core_vld_o,
  output cluster_pkg::data_t [NumCoresPerTile-1:0]       core_rdata_o,
  // Crossbar master side
  output logic [NumCoresPerTile-1:0]                     xbar_req_o,
  output logic [NumCoresPerTile-1:0][BankSelWidth-1:0]   xbar_bank_o,
  output cluster_pkg::bank_req_t [NumCoresPerTile-1:0]   xbar_qry_o,
  input  logic [NumCoresPerTile-1:0]                     xbar_gnt_i,
  input  logic [NumCoresPerTile-1:0]                     xbar_vld_i,
  input  cluster_pkg::data_t [NumCoresPerTile-1:0]       xbar_rdata_i,
  // Bank side
  input  logic [NumBanksPerTile-1:0]                     mem_req_i,
  input  cluster_pkg::bank_req_t [NumBanksPerTile-1:0]   mem_qry_i,
  output logic [NumBanksPerTile-1:0]                     mem_vld_o,
  output cluster_pkg::bank_resp_t [NumBanksPerTile-1:0]  mem_resp_o
);

  import cluster_pkg::*;

  localparam int unsigned OffWidth   = $clog2(BeWidth);
  localparam int unsigned UpperWidth = AddrWidth - RowWidth - BankSelWidth - OffWidth;
  localparam addr_t       WindowSize = addr_t'(NumBanks * TCDMSizePerBank);

  // Word-interleaved split of a window-relative address
  typedef struct packed {
    logic [UpperWidth-1:0]   upper;
    logic [RowWidth-1:0]     row;
    logic [BankSelWidth-1:0] bank;
    logic [OffWidth-1:0]     offset;
  } addr_fields_t;

  typedef union packed {
    addr_t        raw;
    addr_fields_t field;
  } tcdm_addr_t;

  tcdm_addr_t [NumCoresPerTile-1:0] local_addr;
  logic [NumCoresPerTile-1:0]       in_range;
  logic [NumCoresPerTile-1:0]       err_vld_q;

  always_comb begin
    for (int unsigned c = 0; c < NumCoresPerTile; c++) begin
      // Below-base addresses wrap high and fail the size check
      local_addr[c].raw = core_qry_i[c].addr - TCDMBaseAddr;
      in_range[c]       = local_addr[c].raw < WindowSize;

      xbar_req_o[c]       = core_req_i[c] && in_range[c];
      xbar_bank_o[c]      = local_addr[c].field.bank;
      xbar_qry_o[c].row   = MaxRowWidth'(local_addr[c].field.row);
      xbar_qry_o[c].ini   = ini_t'(tile_id_i * NumCoresPerTile + c);
      xbar_qry_o[c].wen   = core_qry_i[c].wen;
      xbar_qry_o[c].wdata = core_qry_i[c].wdata;
      xbar_qry_o[c].be    = core_qry_i[c].be;

      // Out-of-range requests are accepted at once
      core_gnt_o[c] = in_range[c] ? xbar_gnt_i[c] : core_req_i[c];

      core_vld_o[c]   = xbar_vld_i[c] || err_vld_q[c];
      core_rdata_o[c] = err_vld_q[c] ? ErrData : xbar_rdata_i[c];
    end
  end

  // Error reply one cycle after an out-of-range read, writes dropped
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_vld_q <= '0;
    end else begin
      for (int unsigned c = 0; c < NumCoresPerTile; c++) begin
        err_vld_q[c] <= core_req_i[c] && !in_range[c] && !core_qry_i[c].wen;
      end
    end
  end

  for (genvar k = 0; k < NumBanksPerTile; k++) begin : gen_banks
    tcdm_bank #(
      .RowWidth(RowWidth)
    ) i_bank (
      .clk_i  (clk_i        ),
      .reset_i(reset_i      ),
      .req_i  (mem_req_i[k] ),
      .qry_i  (mem_qry_i[k] ),
      .vld_o  (mem_vld_o[k] ),
      .resp_o (mem_resp_o[k])
    );
  end : gen_banks

endmodule : cluster_tile

// File: hw/l1_cluster.sv
////////////////////
// Shared-L1 cluster top, tiles joined by one crossbar
////////////////////

`timescale 1ns/1ps

module l1_cluster #(
  parameter int unsigned        NumCores        = 4,
  parameter int unsigned        NumCoresPerTile = 2,
  parameter int unsigned        BankingFactor   = 2,
  parameter cluster_pkg::addr_t TCDMBaseAddr    = 32'h0001_0000,
  parameter int unsigned        TCDMSizePerBank = 256,
  // Derived from the ones above
  parameter int unsigned NumTiles        = NumCores / NumCoresPerTile,
  parameter int unsigned NumBanks        = NumCores * BankingFactor,
  parameter int unsigned NumBanksPerTile = NumBanks / NumTiles,
  parameter int unsigned RowWidth        = $clog2(TCDMSizePerBank / cluster_pkg::BeWidth)
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [NumCores-1:0]                   core_req_i,
  input  cluster_pkg::tcdm_req_t [NumCores-1:0] core_qry_i,
  output logic [NumCores-1:0]                   core_gnt_o,
  output logic [NumCores-1:0]                   core_vld_o,
  output cluster_pkg::data_t [NumCores-1:0]     core_rdata_o
);

  import cluster_pkg::*;

  localparam int unsigned BankSelWidth = (NumBanks > 1) ? $clog2(NumBanks) : 1;

  // Core ports towards the crossbar
  logic [NumCores-1:0]                   xbar_req;
  logic [NumCores-1:0][BankSelWidth-1:0] xbar_bank;
  bank_req_t [NumCores-1:0]              xbar_qry;
  logic [NumCores-1:0]                   xbar_gnt;
  logic [NumCores-1:0]                   xbar_vld;
  data_t [NumCores-1:0]                  xbar_rdata;

  // Crossbar towards the banks
  logic [NumBanks-1:0]       bank_req;
  bank_req_t [NumBanks-1:0]  bank_qry;
  logic [NumBanks-1:0]       bank_vld;
  bank_resp_t [NumBanks-1:0] bank_resp;

  for (genvar t = 0; t < NumTiles; t++) begin : gen_tiles
    cluster_tile #(
      .NumCoresPerTile(NumCoresPerTile),
      .NumBanksPerTile(NumBanksPerTile),
      .NumBanks       (NumBanks       ),
      .TCDMBaseAddr   (TCDMBaseAddr   ),
      .TCDMSizePerBank(TCDMSizePerBank),
      .RowWidth       (RowWidth       )
    ) i_tile (
      .clk_i       (clk_i                                                ),
      .reset_i     (reset_i                                              ),
      .tile_id_i   (MaxIniWidth'(t)                                      ),
      .core_req_i  (core_req_i[NumCoresPerTile*t +: NumCoresPerTile]     ),
      .core_qry_i  (core_qry_i[NumCoresPerTile*t +: NumCoresPerTile]     ),
      .core_gnt_o  (core_gnt_o[NumCoresPerTile*t +: NumCoresPerTile]     ),
      .core_vld_o  (core_vld_o[NumCoresPerTile*t +: NumCoresPerTile]     ),
      .core_rdata_o(core_rdata_o[NumCoresPerTile*t +: NumCoresPerTile]   ),
      .xbar_req_o  (xbar_req[NumCoresPerTile*t +: NumCoresPerTile]       ),
      .xbar_bank_o (xbar_bank[NumCoresPerTile*t +: NumCoresPerTile]      ),
      .xbar_qry_o  (xbar_qry[NumCoresPerTile*t +: NumCoresPerTile]       ),
      .xbar_gnt_i  (xbar_gnt[NumCoresPerTile*t +: NumCoresPerTile]       ),
      .xbar_vld_i  (xbar_vld[NumCoresPerTile*t +: NumCoresPerTile]       ),
      .xbar_rdata_i(xbar_rdata[NumCoresPerTile*t +: NumCoresPerTile]     ),
      .mem_req_i   (bank_req[NumBanksPerTile*t +: NumBanksPerTile]       ),
      .mem_qry_i   (bank_qry[NumBanksPerTile*t +: NumBanksPerTile]       ),
      .mem_vld_o   (bank_vld[NumBanksPerTile*t +: NumBanksPerTile]       ),
      .mem_resp_o  (bank_resp[NumBanksPerTile*t +: NumBanksPerTile]      )
    );
  end : gen_tiles

  tcdm_xbar #(
    .NumIn   (NumCores),
    .NumBanks(NumBanks),
    .RowWidth(RowWidth)
  ) i_xbar (
    .clk_i      (clk_i     ),
    .reset_i    (reset_i   ),
    .req_i      (xbar_req  ),
    .bank_sel_i (xbar_bank ),
    .qry_i      (xbar_qry  ),
    .gnt_o      (xbar_gnt  ),
    .vld_o      (xbar_vld  ),
    .rdata_o    (xbar_rdata),
    .bank_req_o (bank_req  ),
    .bank_qry_o (bank_qry  ),
    .bank_vld_i (bank_vld  ),
    .bank_resp_i(bank_resp )
  );

  // Elaboration-time parameter checks
  if (NumCores != NumTiles * NumCoresPerTile)
    $fatal(1, "[l1_cluster] NumCores is not a multiple of NumCoresPerTile");

  if (BankingFactor < 1 || BankingFactor != 2 ** $clog2(BankingFactor))
    $fatal(1, "[l1_cluster] BankingFactor must be a positive power of two");

  // Bit-field interleaving needs a power-of-two bank count
  if (NumBanks < 2 || NumBanks != 2 ** $clog2(NumBanks))
    $fatal(1, "[l1_cluster] NumBanks must be a power of two, at least 2");

endmodule : l1_cluster

// File: hw/rr_arbiter.sv
////////////////////
// Round-robin arbiter, one grant per cycle
////////////////////

`timescale 1ns/1ps

module rr_arbiter #(
  parameter int unsigned NumReq = 2
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic [NumReq-1:0] req_i,
  output logic [NumReq-1:0] gnt_o
);

  localparam int unsigned IdxWidth = (NumReq > 1) ? $clog2(NumReq) : 1;

  logic [IdxWidth-1:0] ptr_q;
  logic [IdxWidth-1:0] win_idx;
  logic                found;

  // First requester at or after the pointer wins
  always_comb begin
    int unsigned idx;
    gnt_o   = '0;
    win_idx = '0;
    found   = 1'b0;
    for (int unsigned i = 0; i < NumReq; i++) begin
      idx = ptr_q + i;
      if (idx >= NumReq) begin
        idx = idx - NumReq;
      end
      if (!found && req_i[idx]) begin
        found      = 1'b1;
        gnt_o[idx] = 1'b1;
        win_idx    = IdxWidth'(idx);
      end
    end
  end

  // Pointer moves one past the winner
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (found) begin
      if (int'(win_idx) == int'(NumReq) - 1) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= win_idx + IdxWidth'(1);
      end
    end
  end

endmodule : rr_arbiter

// File: hw/tcdm_bank.sv
////////////////////
// One word-wide scratchpad bank, single cycle read latency
////////////////////

`timescale 1ns/1ps

module tcdm_bank #(
  parameter int unsigned RowWidth = 6
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   req_i,
  input  cluster_pkg::bank_req_t qry_i,
  output logic                   vld_o,
  output cluster_pkg::bank_resp_t resp_o
);

  import cluster_pkg::*;

  localparam int unsigned NumRows   = 2 ** RowWidth;
  localparam int unsigned ByteWidth = DataWidth / BeWidth;

  data_t               mem_q [NumRows];
  logic [RowWidth-1:0] row;
  logic                vld_q;
  bank_resp_t          resp_q;

  assign row = qry_i.row[RowWidth-1:0];

  // Byte-enable write
  always_ff @(posedge clk_i) begin
    if (req_i && qry_i.wen) begin
      for (int unsigned k = 0; k < BeWidth; k++) begin
        if (qry_i.be[k]) begin
          mem_q[row][k*ByteWidth +: ByteWidth] <= qry_i.wdata[k*ByteWidth +: ByteWidth];
        end
      end
    end
  end

  // Read data plus initiator index
  always_ff @(posedge clk_i) begin
    if (req_i && !qry_i.wen) begin
      resp_q.rdata <= mem_q[row];
      resp_q.ini   <= qry_i.ini;
    end
  end

  // Valid only follows reads
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= req_i && !qry_i.wen;
    end
  end

  assign vld_o  = vld_q;
  assign resp_o = resp_q;

endmodule : tcdm_bank

// File: hw/tcdm_xbar.sv
////////////////////
// Full crossbar from every core port to every bank
// Per-bank round-robin, responses steered back by ini
////////////////////

`timescale 1ns/1ps

module tcdm_xbar #(
  parameter int unsigned NumIn        = 4,
  parameter int unsigned NumBanks     = 8,
  parameter int unsigned RowWidth     = 6,
  // Derived, leave at default
  parameter int unsigned BankSelWidth = (NumBanks > 1) ? $clog2(NumBanks) : 1
) (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  // Core side
  input  logic [NumIn-1:0]                          req_i,
  input  logic [NumIn-1:0][BankSelWidth-1:0]        bank_sel_i,
  input  cluster_pkg::bank_req_t [NumIn-1:0]        qry_i,
  output logic [NumIn-1:0]                          gnt_o,
  output logic [NumIn-1:0]                          vld_o,
  output cluster_pkg::data_t [NumIn-1:0]            rdata_o,
  // Bank side
  output logic [NumBanks-1:0]                       bank_req_o,
  output cluster_pkg::bank_req_t [NumBanks-1:0]     bank_qry_o,
  input  logic [NumBanks-1:0]                       bank_vld_i,
  input  cluster_pkg::bank_resp_t [NumBanks-1:0]    bank_resp_i
);

  import cluster_pkg::*;

  // Rows are bank targets, columns are core ports
  logic [NumBanks-1:0][NumIn-1:0] req_mat;
  logic [NumBanks-1:0][NumIn-1:0] gnt_mat;

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    bank_req_t win_qry;

    for (genvar i = 0; i < NumIn; i++) begin : gen_req
      assign req_mat[b][i] = req_i[i] && (bank_sel_i[i] == BankSelWidth'(b));
    end

    rr_arbiter #(
      .NumReq(NumIn)
    ) i_arb (
      .clk_i  (clk_i     ),
      .reset_i(reset_i   ),
      .req_i  (req_mat[b]),
      .gnt_o  (gnt_mat[b])
    );

    // Winner's query, row bits above the bank depth cleared
    always_comb begin
      win_qry = '0;
      for (int unsigned i = 0; i < NumIn; i++) begin
        if (gnt_mat[b][i]) begin
          win_qry = qry_i[i];
        end
      end
      win_qry.row = MaxRowWidth'(win_qry.row[RowWidth-1:0]);
    end

    // Banks never stall
    assign bank_req_o[b] = |gnt_mat[b];
    assign bank_qry_o[b] = win_qry;
  end : gen_bank

  // A port is granted by at most one bank
  always_comb begin
    gnt_o = '0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      for (int unsigned i = 0; i < NumIn; i++) begin
        gnt_o[i] |= gnt_mat[b][i];
      end
    end
  end

  // Response routing, no extra register
  always_comb begin
    vld_o   = '0;
    rdata_o = '0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      if (bank_vld_i[b]) begin
        for (int unsigned i = 0; i < NumIn; i++) begin
          if (bank_resp_i[b].ini == ini_t'(i)) begin
            vld_o[i]   = 1'b1;
            rdata_o[i] = bank_resp_i[b].rdata;
          end
        end
      end
    end
  end

endmodule : tcdm_xbar

// File: l1_cluster.f
hw/cluster_pkg.sv
hw/rr_arbiter.sv
hw/tcdm_bank.sv
hw/tcdm_xbar.sv
hw/cluster_tile.sv
hw/l1_cluster.sv
verif/l1_cluster_chk.sv
verif/tb_l1_cluster.sv

// File: verif/l1_cluster_chk.sv
////////////////////
// Handshake assertions on the cluster top, bound to l1_cluster
////////////////////

`timescale 1ns/1ps

module l1_cluster_chk #(
  parameter int unsigned NumCores = 4
) (
  input logic                                  clk_i,
  input logic                                  reset_i,
  input logic [NumCores-1:0]                   core_req_i,
  input cluster_pkg::tcdm_req_t [NumCores-1:0] core_qry_i,
  input logic [NumCores-1:0]                   core_gnt_o,
  input logic [NumCores-1:0]                   core_vld_o
);

  import cluster_pkg::*;

  logic [NumCores-1:0] rd_gnt;

  for (genvar c = 0; c < NumCores; c++) begin : gen_port
    assign rd_gnt[c] = core_req_i[c] && core_gnt_o[c] && !core_qry_i[c].wen;

    gnt_needs_req : assert property (@(posedge clk_i) disable iff (reset_i)
      core_gnt_o[c] |-> core_req_i[c])
      else $error("Grant on port %0d without a request", c);

    // Fixed one-cycle read latency
    read_gets_vld : assert property (@(posedge clk_i) disable iff (reset_i)
      rd_gnt[c] |=> core_vld_o[c])
      else $error("Read granted on port %0d got no response next cycle", c);

    vld_needs_read : assert property (@(posedge clk_i) disable iff (reset_i)
      core_vld_o[c] |-> $past(rd_gnt[c]))
      else $error("Response on port %0d without a read grant before it", c);
  end : gen_port

endmodule : l1_cluster_chk

bind l1_cluster l1_cluster_chk #(
  .NumCores(NumCores)
) i_chk (
  .clk_i     (clk_i     ),
  .reset_i   (reset_i   ),
  .core_req_i(core_req_i),
  .core_qry_i(core_qry_i),
  .core_gnt_o(core_gnt_o),
  .core_vld_o(core_vld_o)
);

// File: verif/tb_l1_cluster.sv
////////////////////
// Testbench for l1_cluster that plays the cores against a byte model
// Fill, directed table, then an LFSR-driven random phase
////////////////////

`timescale 1ns/1ps

module tb_l1_cluster;

  import cluster_pkg::*;

  localparam int unsigned NumCores        = 4;
  localparam int unsigned BankingFactor   = 2;
  localparam int unsigned TCDMSizePerBank = 256;
  localparam addr_t       TCDMBaseAddr    = 32'h0001_0000;
  localparam int unsigned WindowBytes     = NumCores * BankingFactor * TCDMSizePerBank;
  localparam int unsigned NumWords        = WindowBytes / BeWidth;
  localparam int unsigned WordBits        = $clog2(NumWords);
  localparam int unsigned ClkPeriod       = 20;
  localparam int unsigned NumSteps        = 11;
  localparam int unsigned FillSteps       = NumWords / NumCores;
  localparam int unsigned RandSteps       = 200;
  localparam int unsigned WatchdogCycles  =
    (NumSteps + FillSteps + RandSteps) * NumCores * 40 + 20;

  typedef struct packed {
    logic      req;
    tcdm_req_t qry;
  } op_t;

  logic                     clk_i;
  logic                     reset_i;
  logic [NumCores-1:0]      core_req_i;
  tcdm_req_t [NumCores-1:0] core_qry_i;
  logic [NumCores-1:0]      core_gnt_o;
  logic [NumCores-1:0]      core_vld_o;
  data_t [NumCores-1:0]     core_rdata_o;

  op_t [NumCores-1:0] tbl [NumSteps];
  int unsigned        tbl_cycles [NumSteps];
  logic [7:0]         model [WindowBytes];
  logic [NumCores-1:0] exp_vld;
  data_t              exp_data [NumCores];
  logic [31:0]        lfsr_q;
  int unsigned        errors;
  int unsigned        checks;

  l1_cluster i_dut (
    .clk_i       (clk_i       ),
    .reset_i     (reset_i     ),
    .core_req_i  (core_req_i  ),
    .core_qry_i  (core_qry_i  ),
    .core_gnt_o  (core_gnt_o  ),
    .core_vld_o  (core_vld_o  ),
    .core_rdata_o(core_rdata_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  function automatic logic in_window(input addr_t addr);
    return addr_t'(addr - TCDMBaseAddr) < addr_t'(WindowBytes);
  endfunction

  function automatic data_t read_model(input addr_t addr);
    addr_t base;
    data_t word;
    if (!in_window(addr)) begin
      return ErrData;
    end
    base = addr_t'(addr - TCDMBaseAddr) & ~addr_t'(BeWidth - 1);
    for (int unsigned k = 0; k < BeWidth; k++) begin
      word[8*k +: 8] = model[base + k];
    end
    return word;
  endfunction

  // Out-of-range writes leave the model untouched
  function automatic void write_model(input tcdm_req_t qry);
    addr_t base;
    if (in_window(qry.addr)) begin
      base = addr_t'(qry.addr - TCDMBaseAddr) & ~addr_t'(BeWidth - 1);
      for (int unsigned k = 0; k < BeWidth; k++) begin
        if (qry.be[k]) begin
          model[base + k] = qry.wdata[8*k +: 8];
        end
      end
    end
  endfunction

  // Galois LFSR on x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    logic        b;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      b      = lfsr_q[0];
      lfsr_q = b ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      val    = {val[30:0], b};
    end
    return val;
  endfunction

  function automatic op_t rand_op();
    op_t                 op;
    logic                oor;
    logic [WordBits-1:0] word;
    op.req       = 1'(rand_bits(1));
    op.qry.wen   = 1'(rand_bits(1));
    oor          = (rand_bits(4) == 0);
    word         = WordBits'(rand_bits(WordBits));
    op.qry.wdata = rand_bits(32);
    op.qry.be    = BeWidth'(rand_bits(BeWidth));
    op.qry.addr  = TCDMBaseAddr + (oor ? addr_t'(WindowBytes) : '0) + addr_t'({word, 2'b00});
    return op;
  endfunction

  // Depends on every address bit
  function automatic data_t fill_word(input addr_t addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'hc3a5_9617;
  endfunction

  task automatic load_table();
    for (int unsigned s = 0; s < NumSteps; s++) begin
      tbl[s] = '0;
    end
    // Full write, partial overwrite, read back the merge
    tbl[0][0] = {1'b1, 32'h0001_0040, 1'b1, 32'h1122_3344, 4'hf};
    tbl[1][0] = {1'b1, 32'h0001_0040, 1'b1, 32'haabb_ccdd, 4'h5};
    tbl[2][0] = {1'b1, 32'h0001_0040, 1'b0, 32'h0000_0000, 4'h0};
    // Consecutive words on four distinct banks
    tbl[3][0] = {1'b1, 32'h0001_0100, 1'b1, 32'h0102_0304, 4'hf};
    tbl[3][1] = {1'b1, 32'h0001_0104, 1'b1, 32'h0506_0708, 4'hf};
    tbl[3][2] = {1'b1, 32'h0001_0108, 1'b1, 32'h090a_0b0c, 4'hf};
    tbl[3][3] = {1'b1, 32'h0001_010c, 1'b1, 32'h0d0e_0f10, 4'hf};
    tbl[4][0] = {1'b1, 32'h0001_0100, 1'b0, 32'h0000_0000, 4'h0};
    tbl[4][1] = {1'b1, 32'h0001_0104, 1'b0, 32'h0000_0000, 4'h0};
    tbl[4][2] = {1'b1, 32'h0001_0108, 1'b0, 32'h0000_0000, 4'h0};
    tbl[4][3] = {1'b1, 32'h0001_010c, 1'b0, 32'h0000_0000, 4'h0};
    // All on bank 0
    tbl[5][0] = {1'b1, 32'h0001_0200, 1'b1, 32'h5555_0000, 4'hf};
    tbl[5][1] = {1'b1, 32'h0001_0220, 1'b1, 32'h5555_1111, 4'hf};
    tbl[5][2] = {1'b1, 32'h0001_0240, 1'b1, 32'h5555_2222, 4'hf};
    tbl[5][3] = {1'b1, 32'h0001_0260, 1'b1, 32'h5555_3333, 4'hf};
    tbl[6][0] = {1'b1, 32'h0001_0260, 1'b0, 32'h0000_0000, 4'h0};
    tbl[6][1] = {1'b1, 32'h0001_0240, 1'b0, 32'h0000_0000, 4'h0};
    tbl[6][2] = {1'b1, 32'h0001_0220, 1'b0, 32'h0000_0000, 4'h0};
    tbl[6][3] = {1'b1, 32'h0001_0200, 1'b0, 32'h0000_0000, 4'h0};
    // Out-of-range reads below and above the window
    tbl[7][1] = {1'b1, 32'h0000_0100, 1'b0, 32'h0000_0000, 4'h0};
    tbl[7][2] = {1'b1, 32'h0001_0800, 1'b0, 32'h0000_0000, 4'h0};
    tbl[7][3] = {1'b1, 32'h0001_fffc, 1'b0, 32'h0000_0000, 4'h0};
    // Out-of-range writes that would alias words 0 and last
    tbl[8][0] = {1'b1, 32'h0001_0800, 1'b1, 32'hdead_beef, 4'hf};
    tbl[8][3] = {1'b1, 32'h0000_fffc, 1'b1, 32'hdead_beef, 4'hf};
    tbl[9][0] = {1'b1, 32'h0001_0000, 1'b0, 32'h0000_0000, 4'h0};
    tbl[9][3] = {1'b1, 32'h0001_07fc, 1'b0, 32'h0000_0000, 4'h0};
    // Write and read racing for bank 1
    tbl[10][0] = {1'b1, 32'h0001_0040, 1'b0, 32'h0000_0000, 4'h0};
    tbl[10][1] = {1'b1, 32'h0001_0044, 1'b1, 32'h7700_0000, 4'h8};
    tbl[10][2] = {1'b1, 32'h0001_0044, 1'b0, 32'h0000_0000, 4'h0};
    tbl_cycles = '{1, 1, 1, 1, 1, 4, 4, 1, 1, 1, 2};
  endtask

  // Holds each request until granted
  // A zero exp_cycles skips the cycle count check
  task automatic run_step(input op_t [NumCores-1:0] ops, input int unsigned exp_cycles,
                          input int unsigned step);
    logic [NumCores-1:0] pending;
    int unsigned         cycles;
    for (int unsigned c = 0; c < NumCores; c++) begin
      pending[c]    = ops[c].req;
      core_req_i[c] = ops[c].req;
      core_qry_i[c] = ops[c].qry;
    end
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
      pending = pending & ~core_gnt_o;
      @(posedge clk_i);
      #2;
      core_req_i = core_req_i & pending;
    end while (pending != 0);
    if (exp_cycles != 0 && cycles != exp_cycles) begin
      errors++;
      $display("Step %0d needed %0d cycles for all grants instead of %0d",
               step, cycles, exp_cycles);
    end
  endtask

  // Checks responses before recording this cycle's grants
  always @(negedge clk_i) begin
    if (reset_i === 1'b0) begin
      for (int unsigned c = 0; c < NumCores; c++) begin
        checks++;
        if (core_vld_o[c] !== exp_vld[c]) begin
          errors++;
          $display("ERROR at %0t: core_vld_o[%0d] expected %b, got %b",
                   $time, c, exp_vld[c], core_vld_o[c]);
        end else if (exp_vld[c] && core_rdata_o[c] !== exp_data[c]) begin
          errors++;
          $display("ERROR at %0t: core_rdata_o[%0d] expected %h, got %h",
                   $time, c, exp_data[c], core_rdata_o[c]);
        end
        if (!core_req_i[c] && core_gnt_o[c] !== 1'b0) begin
          errors++;
          $display("ERROR at %0t: core_gnt_o[%0d] expected 0, got %b",
                   $time, c, core_gnt_o[c]);
        end
        exp_vld[c] = 1'b0;
        if (core_req_i[c] && core_gnt_o[c] === 1'b1) begin
          if (core_qry_i[c].wen) begin
            write_model(core_qry_i[c]);
          end else begin
            exp_vld[c]  = 1'b1;
            exp_data[c] = read_model(core_qry_i[c].addr);
          end
        end
      end
    end
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout after %0d cycles, the run did not finish", WatchdogCycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    op_t [NumCores-1:0] ops;
    addr_t              addr;
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    core_req_i = '0;
    core_qry_i = '0;
    exp_vld    = '0;
    lfsr_q     = 32'h5a24_7b2c;
    errors     = 0;
    checks     = 0;
    load_table();
    repeat (4) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    // Idle cycles with nothing granted or returned
    repeat (2) @(posedge clk_i);
    #2;
    // Fill every word with four consecutive words per step
    for (int unsigned f = 0; f < FillSteps; f++) begin
      for (int unsigned c = 0; c < NumCores; c++) begin
        addr   = TCDMBaseAddr + addr_t'((f * NumCores + c) * BeWidth);
        ops[c] = {1'b1, addr, 1'b1, fill_word(addr), 4'hf};
      end
      run_step(ops, 1, f);
    end
    for (int unsigned s = 0; s < NumSteps; s++) begin
      run_step(tbl[s], tbl_cycles[s], s);
    end
    for (int unsigned r = 0; r < RandSteps; r++) begin
      for (int unsigned c = 0; c < NumCores; c++) begin
        ops[c] = rand_op();
      end
      run_step(ops, 0, r);
    end
    repeat (2) @(posedge clk_i);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_l1_cluster
